/* common/audio_mix_pkg.sv */
`include "mixer_settings.svh"

package audio_mix_pkg;

    ////////////////////////////////////////////////////////////
    // Payload types
    ////////////////////////////////////////////////////////////

    typedef logic signed [`MIX_SAMPLE_WIDTH-1:0] sample_t;

    // Gain in half-dB steps
    typedef logic signed [`MIX_GAIN_WIDTH-1:0] gain_t;

    // Linear factor, 256 is unity
    typedef logic signed [`MIX_FACTOR_WIDTH-1:0] factor_t;

    typedef logic signed [`MIX_PRODUCT_WIDTH-1:0] product_t;

    ////////////////////////////////////////////////////////////
    // Whole-dB to Q8 factor lookup
    ////////////////////////////////////////////////////////////

    // Saturates outside +-20 dB to the end entries of the table
    function automatic factor_t db_to_factor(input gain_t db);
        factor_t factor;
        if (db > 20) begin
            factor = 13'sd2560;
        end else if (db < -20) begin
            factor = 13'sd26;
        end else begin
            case (db)
                20:      factor = 13'sd2560;
                19:      factor = 13'sd2281;
                18:      factor = 13'sd2033;
                17:      factor = 13'sd1812;
                16:      factor = 13'sd1615;
                15:      factor = 13'sd1439;
                14:      factor = 13'sd1283;
                13:      factor = 13'sd1143;
                12:      factor = 13'sd1019;
                11:      factor = 13'sd908;
                10:      factor = 13'sd809;
                9:       factor = 13'sd721;
                8:       factor = 13'sd643;
                7:       factor = 13'sd573;
                6:       factor = 13'sd510;
                5:       factor = 13'sd455;
                4:       factor = 13'sd405;
                3:       factor = 13'sd361;
                2:       factor = 13'sd322;
                1:       factor = 13'sd287;
                0:       factor = 13'sd256;
                -1:      factor = 13'sd228;
                -2:      factor = 13'sd203;
                -3:      factor = 13'sd181;
                -4:      factor = 13'sd161;
                -5:      factor = 13'sd143;
                -6:      factor = 13'sd128;
                -7:      factor = 13'sd114;
                -8:      factor = 13'sd102;
                -9:      factor = 13'sd91;
                -10:     factor = 13'sd81;
                -11:     factor = 13'sd72;
                -12:     factor = 13'sd64;
                -13:     factor = 13'sd57;
                -14:     factor = 13'sd51;
                -15:     factor = 13'sd46;
                -16:     factor = 13'sd41;
                -17:     factor = 13'sd36;
                -18:     factor = 13'sd32;
                -19:     factor = 13'sd29;
                -20:     factor = 13'sd26;
                default: factor = 13'sd256;
            endcase
        end
        return factor;
    endfunction

endpackage

/* common/mixer_settings.svh */
`ifndef MIXER_SETTINGS_SVH
`define MIXER_SETTINGS_SVH

// Number of mixer inputs, any value from 2 to 8 works
`define MIX_CHANNELS 4

// Sample and gain word widths
`define MIX_SAMPLE_WIDTH 12
`define MIX_GAIN_WIDTH 9

// Q8 linear factor and the full multiplier result
`define MIX_FACTOR_WIDTH 13
`define MIX_PRODUCT_WIDTH 25

// Clock edges from the start pulse to done in a gain stage
`define MIX_STAGE_LATENCY 4

`endif

/* compile.f */
+incdir+common
common/audio_mix_pkg.sv
gain_stage/variable_gain.sv
source/channel_loader.sv
source/mix_accumulator.sv
source/audio_mixer_top.sv
tb/mixer_checker.sv
tb/mixer_tb.sv

/* gain_stage/variable_gain.sv */
`timescale 1ns/10ps
`include "mixer_settings.svh"

module variable_gain (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  start,
    input  audio_mix_pkg::sample_t incoming_sample,
    input  audio_mix_pkg::gain_t   input_gain,
    output audio_mix_pkg::sample_t scaled_sample,
    output logic                  done
);

    import audio_mix_pkg::*;

    typedef enum logic [1:0] {
        IDLE              = 2'b00,
        FIND_GAIN         = 2'b01,
        APPLY_GAIN        = 2'b10,
        DIVIDE_AND_OUTPUT = 2'b11
    } stage_state_t;

    stage_state_t state;

    // Pipeline working registers
    gain_t    gain_db;
    factor_t  factor;
    product_t product;

    ////////////////////////////////////////////////////////////
    // Control path
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= IDLE;
            done  <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    // A new frame clears the previous result flag
                    if (start) begin
                        done  <= 1'b0;
                        state <= FIND_GAIN;
                    end
                end
                FIND_GAIN: begin
                    state <= APPLY_GAIN;
                end
                APPLY_GAIN: begin
                    state <= DIVIDE_AND_OUTPUT;
                end
                DIVIDE_AND_OUTPUT: begin
                    done  <= 1'b1;
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Data path
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        case (state)
            IDLE: begin
                // Half-dB to whole dB, rounds toward minus infinity
                if (start) begin
                    gain_db <= input_gain >>> 1;
                end
            end
            FIND_GAIN: begin
                factor <= db_to_factor(gain_db);
            end
            APPLY_GAIN: begin
                product <= incoming_sample * factor;
            end
            DIVIDE_AND_OUTPUT: begin
                // Drop the Q8 fraction, upper bits wrap
                scaled_sample <= product[19:8];
            end
            default: begin
                product <= product;
            end
        endcase
    end

    // Result flag stays low while the pipeline is working
    assert property (@(posedge clock) disable iff (reset)
        (state == FIND_GAIN || state == APPLY_GAIN) |-> !done);

endmodule

/* run_sim.sh */
#!/bin/sh
# Build the mixer testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f compile.f --top-module mixer_tb

if ! output=$(./obj_dir/Vmixer_tb); then
    printf '%s\n' "$output"
    echo "Simulation exited with an error"
    exit 1
fi

printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "TEST PASS"; then
    exit 0
fi
exit 1

/* source/audio_mixer_top.sv */
`timescale 1ns/10ps
`include "mixer_settings.svh"

module audio_mixer_top (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  sample_strobe,
    input  audio_mix_pkg::sample_t sample_in [`MIX_CHANNELS],
    input  audio_mix_pkg::gain_t   gain_in [`MIX_CHANNELS],
    output logic                  ready,
    output audio_mix_pkg::sample_t mixed_sample,
    output logic                  mixed_valid,
    output logic                  clipped
);

    import audio_mix_pkg::*;

    // Registered frame from the loader
    sample_t sample_reg [`MIX_CHANNELS];
    gain_t   gain_reg [`MIX_CHANNELS];
    logic    start;

    // Per-channel results
    sample_t channel_sample [`MIX_CHANNELS];
    logic    channel_done [`MIX_CHANNELS];

    ////////////////////////////////////////////////////////////
    // Frame capture
    ////////////////////////////////////////////////////////////

    channel_loader u_loader (
        .clock         (clock),
        .reset         (reset),
        .sample_strobe (sample_strobe),
        .sample_in     (sample_in),
        .gain_in       (gain_in),
        .sample_reg    (sample_reg),
        .gain_reg      (gain_reg),
        .start         (start),
        .ready         (ready)
    );

    ////////////////////////////////////////////////////////////
    // Channel gain stages
    ////////////////////////////////////////////////////////////

    // All stages share the one start pulse and run in lockstep
    for (genvar ch = 0; ch < `MIX_CHANNELS; ch++) begin : g_channel
        variable_gain u_gain (
            .clock           (clock),
            .reset           (reset),
            .start           (start),
            .incoming_sample (sample_reg[ch]),
            .input_gain      (gain_reg[ch]),
            .scaled_sample   (channel_sample[ch]),
            .done            (channel_done[ch])
        );
    end

    ////////////////////////////////////////////////////////////
    // Sum and saturate
    ////////////////////////////////////////////////////////////

    mix_accumulator u_mix (
        .clock          (clock),
        .reset          (reset),
        .channel_sample (channel_sample),
        .channel_done   (channel_done),
        .mixed_sample   (mixed_sample),
        .mixed_valid    (mixed_valid),
        .clipped        (clipped)
    );

endmodule

/* source/channel_loader.sv */
`timescale 1ns/10ps
`include "mixer_settings.svh"

module channel_loader (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  sample_strobe,
    input  audio_mix_pkg::sample_t sample_in [`MIX_CHANNELS],
    input  audio_mix_pkg::gain_t   gain_in [`MIX_CHANNELS],
    output audio_mix_pkg::sample_t sample_reg [`MIX_CHANNELS],
    output audio_mix_pkg::gain_t   gain_reg [`MIX_CHANNELS],
    output logic                  start,
    output logic                  ready
);

    // Stage latency plus one edge in the accumulator
    localparam int BUSY_CYCLES = `MIX_STAGE_LATENCY + 1;
    localparam int COUNT_WIDTH = $clog2(BUSY_CYCLES + 1);

    logic [COUNT_WIDTH-1:0] busy_count;
    logic                   accept;

    // Strobes outside the ready window are dropped
    assign accept = sample_strobe && ready;
    assign ready  = (busy_count == '0);

    ////////////////////////////////////////////////////////////
    // Start pulse and busy window
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            start      <= 1'b0;
            busy_count <= '0;
        end else begin
            start <= accept;
            if (accept) begin
                busy_count <= COUNT_WIDTH'(BUSY_CYCLES);
            end else if (busy_count != '0) begin
                busy_count <= busy_count - 1'b1;
            end
        end
    end

    // Frame capture held steady for the whole pipeline
    always_ff @(posedge clock) begin
        if (accept) begin
            sample_reg <= sample_in;
            gain_reg   <= gain_in;
        end
    end

    // Ready is already low while the start pulse is out
    assert property (@(posedge clock) disable iff (reset)
        start |-> !ready);

endmodule

/* source/mix_accumulator.sv */
`timescale 1ns/10ps
`include "mixer_settings.svh"

module mix_accumulator (
    input  logic                  clock,
    input  logic                  reset,
    input  audio_mix_pkg::sample_t channel_sample [`MIX_CHANNELS],
    input  logic                  channel_done [`MIX_CHANNELS],
    output audio_mix_pkg::sample_t mixed_sample,
    output logic                  mixed_valid,
    output logic                  clipped
);

    // Enough headroom for every channel at full scale
    localparam int SUM_WIDTH = `MIX_SAMPLE_WIDTH + $clog2(`MIX_CHANNELS);

    localparam logic signed [SUM_WIDTH-1:0] SAT_MAX =
        SUM_WIDTH'((2 ** (`MIX_SAMPLE_WIDTH - 1)) - 1);
    localparam logic signed [SUM_WIDTH-1:0] SAT_MIN = -SAT_MAX - 1;

    logic                                all_done;
    logic                                prev_all_done;
    logic                                fire;
    logic signed [SUM_WIDTH-1:0]         sum;
    logic signed [`MIX_SAMPLE_WIDTH-1:0] sat_sum;
    logic                                saturated;

    ////////////////////////////////////////////////////////////
    // Completion detect and summing
    ////////////////////////////////////////////////////////////

    always_comb begin
        all_done = 1'b1;
        sum      = '0;
        for (int ch = 0; ch < `MIX_CHANNELS; ch++) begin
            all_done = all_done & channel_done[ch];
            sum      = sum + channel_sample[ch];
        end
    end

    // Only the rising edge of the combined done counts
    assign fire = all_done && !prev_all_done;

    always_comb begin
        saturated = 1'b1;
        if (sum > SAT_MAX) begin
            sat_sum = SAT_MAX[`MIX_SAMPLE_WIDTH-1:0];
        end else if (sum < SAT_MIN) begin
            sat_sum = SAT_MIN[`MIX_SAMPLE_WIDTH-1:0];
        end else begin
            sat_sum   = sum[`MIX_SAMPLE_WIDTH-1:0];
            saturated = 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////
    // Output register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            prev_all_done <= 1'b0;
            mixed_valid   <= 1'b0;
            clipped       <= 1'b0;
            mixed_sample  <= '0;
        end else begin
            prev_all_done <= all_done;
            mixed_valid   <= fire;
            clipped       <= fire && saturated;
            if (fire) begin
                mixed_sample <= sat_sum;
            end
        end
    end

    // One frame gives exactly one result pulse
    assert property (@(posedge clock) disable iff (reset)
        mixed_valid |=> !mixed_valid);

endmodule

/* tb/mixer_checker.sv */
`timescale 1ns/10ps
`include "mixer_settings.svh"

module mixer_checker (
    input  logic                   clock,
    input  logic                   reset,
    input  logic [2:0]             phase,
    input  logic                   sample_strobe,
    input  audio_mix_pkg::sample_t sample_in [`MIX_CHANNELS],
    input  audio_mix_pkg::gain_t   gain_in [`MIX_CHANNELS],
    input  logic                   ready,
    input  audio_mix_pkg::sample_t mixed_sample,
    input  logic                   mixed_valid,
    input  logic                   clipped,
    output int                     value_errors,
    output int                     protocol_errors,
    output int                     pending_results
);

    import audio_mix_pkg::*;

    // Accepted strobe edge to the edge that raises mixed_valid
    localparam int VALID_DELAY = `MIX_STAGE_LATENCY + 1;
    localparam int SAMPLE_MAX  = (1 << (`MIX_SAMPLE_WIDTH - 1)) - 1;
    localparam int SAMPLE_MIN  = -SAMPLE_MAX - 1;

    int      edge_count = 0;
    logic    reset_at_edge = 1'b1;
    int      busy = 0;
    int      value_count = 0;
    int      protocol_count = 0;
    int      pending_count = 0;

    // Expected results in arrival order
    sample_t exp_sample_q [$];
    logic    exp_clip_q [$];
    int      exp_edge_q [$];

    assign value_errors    = value_count;
    assign protocol_errors = protocol_count;
    assign pending_results = pending_count;

    function automatic string phase_name(input logic [2:0] id);
        case (id)
            3'd1:    return "unity_small";
            3'd2:    return "gain_clamp";
            3'd3:    return "saturation";
            3'd4:    return "strobe_timing";
            default: return "idle";
        endcase
    endfunction

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    // Whole dB is the floor of half-dB over two, clamped to the table range
    function automatic sample_t scale_channel(input sample_t sample, input gain_t gain);
        int          half_db;
        int          whole_db;
        int          product;
        logic [31:0] product_bits;
        half_db = gain;
        if (half_db < 0) begin
            whole_db = -((1 - half_db) / 2);
        end else begin
            whole_db = half_db / 2;
        end
        if (whole_db > 20) begin
            whole_db = 20;
        end else if (whole_db < -20) begin
            whole_db = -20;
        end
        product      = int'(sample) * int'(db_to_factor(gain_t'(whole_db)));
        product_bits = product;
        // Bits 19..8 of the product
        return sample_t'(product_bits[19:8]);
    endfunction

    function automatic void model_frame(output sample_t result, output logic saturated);
        int sum;
        sum = 0;
        for (int ch = 0; ch < `MIX_CHANNELS; ch++) begin
            sum = sum + int'(scale_channel(sample_in[ch], gain_in[ch]));
        end
        saturated = 1'b1;
        if (sum > SAMPLE_MAX) begin
            result = sample_t'(SAMPLE_MAX);
        end else if (sum < SAMPLE_MIN) begin
            result = sample_t'(SAMPLE_MIN);
        end else begin
            result    = sample_t'(sum);
            saturated = 1'b0;
        end
    endfunction

    ////////////////////////////////////////////////////////////
    // Port monitor
    ////////////////////////////////////////////////////////////

    always @(posedge clock) begin
        edge_count    <= edge_count + 1;
        reset_at_edge <= reset;
    end

    // Everything is stable at the falling edge
    always @(negedge clock) begin : compare
        sample_t exp_sample;
        logic    exp_clip;
        if (reset_at_edge) begin
            if (ready !== 1'b1 || mixed_valid !== 1'b0 || clipped !== 1'b0) begin
                $display("Outputs wrong in reset at edge %0d: ready %b, valid %b, clipped %b",
                         edge_count, ready, mixed_valid, clipped);
                protocol_count++;
            end
            if (mixed_sample !== '0) begin
                $display("FAILED reset: mixed_sample expected 0 actual %0d", mixed_sample);
                value_count++;
            end
            exp_sample_q.delete();
            exp_clip_q.delete();
            exp_edge_q.delete();
        end else begin
            if (ready !== (busy == 0)) begin
                $display("ready is %b at edge %0d in %s but should be %b",
                         ready, edge_count, phase_name(phase), busy == 0);
                protocol_count++;
            end
            if (clipped === 1'b1 && mixed_valid !== 1'b1) begin
                $display("clipped is high without mixed_valid at edge %0d", edge_count);
                protocol_count++;
            end
            if (exp_edge_q.size() > 0 && exp_edge_q[0] <= edge_count) begin
                if (mixed_valid === 1'b1) begin
                    if (mixed_sample !== exp_sample_q[0]) begin
                        $display("FAILED %s: mixed_sample expected %0d actual %0d",
                                 phase_name(phase), exp_sample_q[0], mixed_sample);
                        value_count++;
                    end
                    if (clipped !== exp_clip_q[0]) begin
                        $display("FAILED %s: clipped expected %b actual %b",
                                 phase_name(phase), exp_clip_q[0], clipped);
                        value_count++;
                    end
                end else begin
                    $display("mixed_valid missing at edge %0d in %s",
                             edge_count, phase_name(phase));
                    protocol_count++;
                end
                void'(exp_sample_q.pop_front());
                void'(exp_clip_q.pop_front());
                void'(exp_edge_q.pop_front());
            end else if (mixed_valid !== 1'b0) begin
                $display("Unexpected mixed_valid at edge %0d in %s",
                         edge_count, phase_name(phase));
                protocol_count++;
            end
        end

        // What the loader does at the coming edge
        if (reset) begin
            busy = 0;
        end else if (sample_strobe === 1'b1 && ready === 1'b1) begin
            model_frame(exp_sample, exp_clip);
            exp_sample_q.push_back(exp_sample);
            exp_clip_q.push_back(exp_clip);
            exp_edge_q.push_back(edge_count + 1 + VALID_DELAY);
            busy = VALID_DELAY;
        end else if (busy > 0) begin
            busy--;
        end
        pending_count = exp_edge_q.size();
    end

endmodule

/* tb/mixer_tb.sv */
`timescale 1ns/10ps
`include "mixer_settings.svh"

module mixer_tb;

    import audio_mix_pkg::*;

    localparam int CLOCK_PERIOD     = 4;
    localparam int RESET_CYCLES     = 3;
    localparam int FRAMES_PER_PHASE = 200;
    localparam int PHASE_COUNT      = 4;
    // Generous cycle budget per frame
    localparam int WATCHDOG_NS      = PHASE_COUNT * FRAMES_PER_PHASE * 12 * CLOCK_PERIOD;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    logic        clock;
    logic        reset;
    logic        sample_strobe;
    sample_t     sample_in [`MIX_CHANNELS];
    gain_t       gain_in [`MIX_CHANNELS];
    logic        ready;
    sample_t     mixed_sample;
    logic        mixed_valid;
    logic        clipped;
    logic [2:0]  phase;
    logic [31:0] lfsr_state;
    int          value_errors;
    int          protocol_errors;
    int          pending_results;

    audio_mixer_top u_dut (
        .clock         (clock),
        .reset         (reset),
        .sample_strobe (sample_strobe),
        .sample_in     (sample_in),
        .gain_in       (gain_in),
        .ready         (ready),
        .mixed_sample  (mixed_sample),
        .mixed_valid   (mixed_valid),
        .clipped       (clipped)
    );

    mixer_checker u_checker (
        .clock           (clock),
        .reset           (reset),
        .phase           (phase),
        .sample_strobe   (sample_strobe),
        .sample_in       (sample_in),
        .gain_in         (gain_in),
        .ready           (ready),
        .mixed_sample    (mixed_sample),
        .mixed_valid     (mixed_valid),
        .clipped         (clipped),
        .value_errors    (value_errors),
        .protocol_errors (protocol_errors),
        .pending_results (pending_results)
    );

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    ////////////////////////////////////////////////////////////
    // Stimulus generators
    ////////////////////////////////////////////////////////////

    // Galois LFSR stepped once per bit
    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        logic        out_bit;
        value = '0;
        for (int i = 0; i < count; i++) begin
            out_bit    = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (out_bit) begin
                lfsr_state = lfsr_state ^ LFSR_TAPS;
            end
            value = {value[30:0], out_bit};
        end
        return value;
    endfunction

    // Mostly -44..+44 half-dB with an occasional range end
    function automatic gain_t normal_gain();
        if (random_bits(3) == 0) begin
            return random_bits(1) ? gain_t'(255) : gain_t'(-256);
        end
        return gain_t'(int'(random_bits(7)) % 89 - 44);
    endfunction

    function automatic gain_t pick_gain(input logic [2:0] id);
        logic [1:0] choice;
        case (id)
            3'd1: begin
                if (random_bits(2) == 0) begin
                    return gain_t'(0);
                end
                return gain_t'(int'(random_bits(4)) % 13 - 6);
            end
            3'd2: begin
                choice = random_bits(2);
                if (choice == 0) begin
                    return gain_t'(random_bits(`MIX_GAIN_WIDTH));
                end else if (choice == 1) begin
                    case (random_bits(3))
                        0:       return gain_t'(-256);
                        1:       return gain_t'(255);
                        2:       return gain_t'(-41);
                        3:       return gain_t'(41);
                        4:       return gain_t'(-40);
                        5:       return gain_t'(40);
                        6:       return gain_t'(-43);
                        default: return gain_t'(43);
                    endcase
                end
                return normal_gain();
            end
            3'd3: begin
                if (random_bits(3) == 0) begin
                    return gain_t'(255);
                end
                return gain_t'(36 + int'(random_bits(3)));
            end
            default: return normal_gain();
        endcase
    endfunction

    function automatic sample_t pick_sample(input logic [2:0] id, input logic negative);
        int magnitude;
        case (id)
            3'd1: begin
                case (random_bits(2))
                    0:       return sample_t'(0);
                    1:       return sample_t'(2047);
                    2:       return sample_t'(-2048);
                    default: return sample_t'(random_bits(`MIX_SAMPLE_WIDTH));
                endcase
            end
            3'd3: begin
                // Same sign on every channel drives the sum into saturation
                if (random_bits(3) == 0) begin
                    return sample_t'(random_bits(`MIX_SAMPLE_WIDTH));
                end
                magnitude = 100 + int'(random_bits(7));
                return negative ? sample_t'(-magnitude) : sample_t'(magnitude);
            end
            default: return sample_t'(random_bits(`MIX_SAMPLE_WIDTH));
        endcase
    endfunction

    ////////////////////////////////////////////////////////////
    // Sequencing
    ////////////////////////////////////////////////////////////

    task automatic drive_inputs(input logic [2:0] id);
        logic negative;
        negative = random_bits(1);
        for (int ch = 0; ch < `MIX_CHANNELS; ch++) begin
            sample_in[ch] = pick_sample(id, negative);
            gain_in[ch]   = pick_gain(id);
        end
        // Busier strobes in the timing phase
        if (id == 3'd4) begin
            sample_strobe = (random_bits(2) != 0);
        end else begin
            sample_strobe = random_bits(1);
        end
    endtask

    task automatic apply_reset();
        reset         = 1'b1;
        sample_strobe = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        #1;
        reset = 1'b0;
    endtask

    task automatic run_phase(input logic [2:0] id);
        int accepted;
        phase = id;
        apply_reset();
        accepted = 0;
        while (accepted < FRAMES_PER_PHASE) begin
            @(posedge clock);
            #1;
            drive_inputs(id);
            @(negedge clock);
            if (sample_strobe && ready) begin
                accepted++;
            end
        end
        @(posedge clock);
        #1;
        sample_strobe = 1'b0;
        // Let the last frame drain
        @(negedge clock);
        while (!ready) begin
            @(negedge clock);
        end
        @(posedge clock);
        #1;
    endtask

    initial begin : main
        lfsr_state    = 32'h23ff8335;
        reset         = 1'b1;
        sample_strobe = 1'b0;
        phase         = 3'd0;
        for (int ch = 0; ch < `MIX_CHANNELS; ch++) begin
            sample_in[ch] = '0;
            gain_in[ch]   = '0;
        end
        for (int id = 1; id <= PHASE_COUNT; id++) begin
            run_phase(3'(id));
        end
        repeat (2) @(negedge clock);
        #1;
        if (pending_results != 0) begin
            $display("%0d expected results never appeared", pending_results);
        end
        $display("Error counts: value %0d, protocol %0d, pending %0d",
                 value_errors, protocol_errors, pending_results);
        if (value_errors == 0 && protocol_errors == 0 && pending_results == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Watchdog timeout: run did not finish within %0d ns", WATCHDOG_NS);
        $display("TEST FAIL");
        $finish;
    end

endmodule
